// ==== frontend_trace.txt ====
// five hex words per record: kind then four fields
// 1 image: addr word, 2 expected: addr instr cf predict_addr, 4 stall: cycles, 0 end
// 3 redirect: code addr_a addr_b (0 mispredict, 1 eret, 2 exception, 3 commit,
//   4 debug, 5 eret with exception, addr_b is then the trap vector)
1 00000100 00000013 0 0
1 00000104 00000463 0 0
1 00000108 0100006f 0 0
1 0000010c 00000013 0 0
1 00000110 0100006f 0 0
1 00000118 fe000ae3 0 0
1 00000120 fe1ff06f 0 0
1 00000800 00000013 0 0
// boot, forward branch, jal, backward branch, jal, backward jal
2 00000100 00000013 0 00000000
2 00000104 00000463 0 00000000
2 00000108 0100006f 2 00000118
2 00000118 fe000ae3 1 0000010c
2 0000010c 00000013 0 00000000
2 00000110 0100006f 2 00000120
2 00000120 fe1ff06f 2 00000100
4 0000000c 0 0 0
2 00000100 00000013 0 00000000
2 00000104 00000463 0 00000000
2 00000108 0100006f 2 00000118
2 00000118 fe000ae3 1 0000010c
2 0000010c 00000013 0 00000000
2 00000110 0100006f 2 00000120
2 00000120 fe1ff06f 2 00000100
2 00000100 00000013 0 00000000
2 00000104 00000463 0 00000000
// redirects
3 00000000 00000110 00000000 0
2 00000110 0100006f 2 00000120
2 00000120 fe1ff06f 2 00000100
3 00000001 00000118 00000000 0
2 00000118 fe000ae3 1 0000010c
2 0000010c 00000013 0 00000000
3 00000002 00000104 00000000 0
2 00000104 00000463 0 00000000
3 00000003 0000010c 00000000 0
2 00000110 0100006f 2 00000120
3 00000004 00000000 00000000 0
2 00000800 00000013 0 00000000
3 00000005 00000118 00000120 0
2 00000120 fe1ff06f 2 00000100
0 0 0 0 0

// ==== all.f ====
+incdir+.
frontend_pkg.sv
instr_scan.sv
fetch_stage.sv
instr_queue.sv
frontend.sv
tb_frontend.sv

// ==== run.sh ====
#!/bin/sh
# compile the frontend testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_frontend -f all.f -o tb_frontend &&
./obj_dir/tb_frontend ||
{ echo "frontend simulation did not pass"; exit 1; }

// ==== tb_frontend.sv ====
// ------------------------------------------------
// frontend testbench
// instruction cache model, trace driven decode
// consumer with random back-pressure, redirect
// driver and entry checks against the trace
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "frontend_defines.svh"

module tb_frontend import frontend_pkg::*; ();

    localparam int TRACE_WORDS = 500;
    localparam int WAIT_LIMIT  = 100;
    localparam logic [`FE_VLEN-1:0] BOOT_ADDR = `FE_VLEN'('h100);

    logic                 clk_i;
    logic                 rst_ni;
    logic [`FE_VLEN-1:0]  boot_addr_i;
    logic                 flush_i;
    resolve_t             resolved_i;
    logic                 eret_i;
    logic [`FE_VLEN-1:0]  epc_i;
    logic                 ex_valid_i;
    logic [`FE_VLEN-1:0]  trap_vector_i;
    logic                 set_pc_commit_i;
    logic [`FE_VLEN-1:0]  pc_commit_i;
    logic                 set_debug_pc_i;
    icache_req_t          icache_req_o;
    icache_rsp_t          icache_rsp_i;
    fetch_entry_t         fetch_entry_o;
    logic                 fetch_entry_valid_o;
    logic                 fetch_entry_ready_i;

    // five words per record, see the trace file header
    logic [31:0]          trace_words [TRACE_WORDS];
    // program image, keyed by word address
    logic [31:0]          imem [logic [31:0]];

    frontend UUT (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .boot_addr_i         (boot_addr_i),
        .flush_i             (flush_i),
        .resolved_i          (resolved_i),
        .eret_i              (eret_i),
        .epc_i               (epc_i),
        .ex_valid_i          (ex_valid_i),
        .trap_vector_i       (trap_vector_i),
        .set_pc_commit_i     (set_pc_commit_i),
        .pc_commit_i         (pc_commit_i),
        .set_debug_pc_i      (set_debug_pc_i),
        .icache_req_o        (icache_req_o),
        .icache_rsp_i        (icache_rsp_i),
        .fetch_entry_o       (fetch_entry_o),
        .fetch_entry_valid_o (fetch_entry_valid_o),
        .fetch_entry_ready_i (fetch_entry_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------------------------
    // instruction cache, always ready, one cycle latency
    // ------------------------------------------------
    initial begin : icache_model
        logic                 pend_req;
        logic [`FE_VLEN-1:0]  pend_addr;
        icache_rsp_i = '0;
        forever begin
            // request is stable mid-cycle
            @(negedge clk_i);
            pend_req  = icache_req_o.req & rst_ni;
            pend_addr = icache_req_o.addr;
            @(posedge clk_i);
            #1;
            icache_rsp_i.valid = pend_req;
            icache_rsp_i.addr  = pend_addr;
            // words outside the image come back as a fetch fault
            if (imem.exists(pend_addr)) begin
                icache_rsp_i.ex   = 1'b0;
                icache_rsp_i.data = imem[pend_addr];
            end else begin
                icache_rsp_i.ex   = 1'b1;
                icache_rsp_i.data = '0;
            end
        end
    end

    // ------------------------------------------------
    // failure reporting and compares
    // ------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_entry(input fetch_entry_t got, input fetch_entry_t exp);
        if (got.addr !== exp.addr) begin
            show_mismatch("fetch_entry_o.addr", got.addr, exp.addr);
        end
        if (got.instr !== exp.instr) begin
            show_mismatch("fetch_entry_o.instr", got.instr, exp.instr);
        end
        if (got.ex !== exp.ex) begin
            show_mismatch("fetch_entry_o.ex", 32'(got.ex), 32'(exp.ex));
        end
        if (got.predict_addr !== exp.predict_addr) begin
            show_mismatch("fetch_entry_o.predict_addr", got.predict_addr, exp.predict_addr);
        end
    endtask

    task automatic check_cf(input cf_e got, input cf_e exp);
        if (got !== exp) begin
            show_mismatch("fetch_entry_o.cf", 32'(got), 32'(exp));
        end
    endtask

    // first entry after reset or a redirect
    task automatic check_addr(input logic [`FE_VLEN-1:0] got, input logic [`FE_VLEN-1:0] exp);
        if (got !== exp) begin
            show_mismatch("fetch_entry_o.addr", got, exp);
        end
    endtask

    // single control bits such as request and valid
    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            show_mismatch(name, 32'(got), 32'(exp));
        end
    endtask

    // where fetch must restart, exception outranks eret when both pulse
    function automatic logic [`FE_VLEN-1:0] redirect_target(input logic [31:0] code,
            input logic [`FE_VLEN-1:0] a, input logic [`FE_VLEN-1:0] b);
        case (code)
            32'd3:   redirect_target = a + `FE_VLEN'(`FE_INSTR_BYTES);
            32'd4:   redirect_target = `FE_DEBUG_ADDR;
            32'd5:   redirect_target = b;
            default: redirect_target = a;
        endcase
    endfunction

    // ------------------------------------------------
    // decode side and redirect drivers
    // ------------------------------------------------
    task automatic take_entry(output fetch_entry_t got);
        int    waited;
        logic  took;
        waited = 0;
        took   = 1'b0;
        got    = '0;
        while (!took) begin
            @(posedge clk_i);
            #1;
            // ready about 60% of the cycles
            fetch_entry_ready_i = (($urandom % 100) < 60);
            @(negedge clk_i);
            if (fetch_entry_valid_o && fetch_entry_ready_i) begin
                got  = fetch_entry_o;
                took = 1'b1;
            end else begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("timeout waiting for an entry from the instruction queue");
                end
            end
        end
    endtask

    task automatic hold_ready(input logic [31:0] cycles);
        for (int unsigned i = 0; i < cycles; i++) begin
            @(posedge clk_i);
            #1;
            fetch_entry_ready_i = 1'b0;
        end
    endtask

    task automatic apply_redirect(input logic [31:0] code, input logic [`FE_VLEN-1:0] a,
                                  input logic [`FE_VLEN-1:0] b);
        @(posedge clk_i);
        #1;
        fetch_entry_ready_i = 1'b0;
        flush_i             = 1'b1;
        case (code)
            32'd0: begin
                resolved_i.valid  = 1'b1;
                resolved_i.target = a;
            end
            32'd1: begin
                eret_i = 1'b1;
                epc_i  = a;
            end
            32'd2: begin
                ex_valid_i    = 1'b1;
                trap_vector_i = a;
            end
            32'd3: begin
                set_pc_commit_i = 1'b1;
                pc_commit_i     = a;
            end
            32'd4: set_debug_pc_i = 1'b1;
            32'd5: begin
                eret_i        = 1'b1;
                epc_i         = a;
                ex_valid_i    = 1'b1;
                trap_vector_i = b;
            end
            default: abort_run("unknown redirect code in the trace");
        endcase
        // single-cycle pulse
        @(posedge clk_i);
        #1;
        flush_i         = 1'b0;
        resolved_i      = '0;
        eret_i          = 1'b0;
        ex_valid_i      = 1'b0;
        set_pc_commit_i = 1'b0;
        set_debug_pc_i  = 1'b0;
    endtask

    // ------------------------------------------------
    // main sequence
    // ------------------------------------------------
    initial begin : main_flow
        fetch_entry_t         got;
        fetch_entry_t         exp_entry;
        logic [`FE_VLEN-1:0]  rule_addr;
        logic                 check_rule;
        logic                 done;
        int                   base;
        int unsigned          seed_draw;
        rst_ni              = 1'b0;
        boot_addr_i         = BOOT_ADDR;
        flush_i             = 1'b0;
        resolved_i          = '0;
        eret_i              = 1'b0;
        epc_i               = '0;
        ex_valid_i          = 1'b0;
        trap_vector_i       = '0;
        set_pc_commit_i     = 1'b0;
        pc_commit_i         = '0;
        set_debug_pc_i      = 1'b0;
        fetch_entry_ready_i = 1'b0;
        seed_draw = $urandom(52);
        $readmemh("frontend_trace.txt", trace_words);
        // image records first, the cache needs them from the start
        for (base = 0; base < TRACE_WORDS; base += 5) begin
            if (trace_words[base] === 32'd1) begin
                imem[trace_words[base+1]] = trace_words[base+2];
            end
        end
        repeat (7) @(posedge clk_i);
        // no fetch and an empty queue while reset is held
        @(negedge clk_i);
        check_flag("icache_req_o.req", icache_req_o.req, 1'b0);
        check_flag("fetch_entry_valid_o", fetch_entry_valid_o, 1'b0);
        @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        // fetch starts at the boot address
        rule_addr  = boot_addr_i;
        check_rule = 1'b1;
        base       = 0;
        done       = 1'b0;
        while (!done) begin
            if (base >= TRACE_WORDS) begin
                abort_run("trace has no end record");
            end
            case (trace_words[base])
                32'd0: done = 1'b1;
                32'd1: begin
                end
                32'd2: begin
                    take_entry(got);
                    if (check_rule) begin
                        check_addr(got.addr, rule_addr);
                        check_rule = 1'b0;
                    end
                    exp_entry.addr         = trace_words[base+1];
                    exp_entry.instr        = trace_words[base+2];
                    exp_entry.ex           = (imem.exists(trace_words[base+1]) == 0);
                    exp_entry.cf           = cf_e'(trace_words[base+3][1:0]);
                    exp_entry.predict_addr = trace_words[base+4];
                    check_entry(got, exp_entry);
                    check_cf(got.cf, exp_entry.cf);
                end
                32'd3: begin
                    apply_redirect(trace_words[base+1], trace_words[base+2],
                                   trace_words[base+3]);
                    rule_addr  = redirect_target(trace_words[base+1], trace_words[base+2],
                                                 trace_words[base+3]);
                    check_rule = 1'b1;
                end
                // decode stalls, queue fills and fetch replays
                32'd4: hold_ready(trace_words[base+1]);
                default: abort_run("unknown record kind in the trace");
            endcase
            base += 5;
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== frontend.sv ====
// ------------------------------------------------
// instruction fetch frontend
// fetch stage with static prediction feeding the
// instruction queue toward decode
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "frontend_defines.svh"

module frontend import frontend_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic [`FE_VLEN-1:0]  boot_addr_i,
    input  wire logic                 flush_i,
    // redirects from the back end
    input  wire resolve_t             resolved_i,
    input  wire logic                 eret_i,
    input  wire logic [`FE_VLEN-1:0]  epc_i,
    input  wire logic                 ex_valid_i,
    input  wire logic [`FE_VLEN-1:0]  trap_vector_i,
    input  wire logic                 set_pc_commit_i,
    input  wire logic [`FE_VLEN-1:0]  pc_commit_i,
    input  wire logic                 set_debug_pc_i,
    // instruction cache
    output icache_req_t               icache_req_o,
    input  wire icache_rsp_t          icache_rsp_i,
    // toward decode
    output fetch_entry_t              fetch_entry_o,
    output logic                      fetch_entry_valid_o,
    input  wire logic                 fetch_entry_ready_i
);

    fetch_entry_t         entry;
    logic                 entry_valid;
    logic                 queue_ready;
    logic                 replay;
    logic [`FE_VLEN-1:0]  replay_addr;

    fetch_stage i_fetch_stage (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .boot_addr_i     (boot_addr_i),
        .flush_i         (flush_i),
        .resolved_i      (resolved_i),
        .eret_i          (eret_i),
        .epc_i           (epc_i),
        .ex_valid_i      (ex_valid_i),
        .trap_vector_i   (trap_vector_i),
        .set_pc_commit_i (set_pc_commit_i),
        .pc_commit_i     (pc_commit_i),
        .set_debug_pc_i  (set_debug_pc_i),
        .icache_req_o    (icache_req_o),
        .icache_rsp_i    (icache_rsp_i),
        .queue_ready_i   (queue_ready),
        .replay_i        (replay),
        .replay_addr_i   (replay_addr),
        .entry_o         (entry),
        .entry_valid_o   (entry_valid)
    );

    // flush also empties the queue
    instr_queue i_instr_queue (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .entry_i             (entry),
        .entry_valid_i       (entry_valid),
        .ready_o             (queue_ready),
        .replay_o            (replay),
        .replay_addr_o       (replay_addr),
        .fetch_entry_o       (fetch_entry_o),
        .fetch_entry_valid_o (fetch_entry_valid_o),
        .fetch_entry_ready_i (fetch_entry_ready_i)
    );

endmodule

`default_nettype wire

// ==== instr_queue.sv ====
// ------------------------------------------------
// instruction queue
// circular buffer of fetch entries toward decode,
// rejects a push when full and asks for a replay
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "frontend_defines.svh"

module instr_queue import frontend_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 flush_i,
    input  wire fetch_entry_t         entry_i,
    input  wire logic                 entry_valid_i,
    output logic                      ready_o,
    output logic                      replay_o,
    output logic [`FE_VLEN-1:0]       replay_addr_o,
    output fetch_entry_t              fetch_entry_o,
    output logic                      fetch_entry_valid_o,
    input  wire logic                 fetch_entry_ready_i
);

    localparam int unsigned DEPTH = `FE_QUEUE_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    fetch_entry_t      mem_q [DEPTH];
    logic [PTR_W-1:0]  rd_ptr_q, wr_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              full;
    logic              push, pop;

    assign full    = (count_q == CNT_W'(DEPTH));
    assign ready_o = ~full;

    assign push = entry_valid_i & ~full;
    assign pop  = fetch_entry_valid_o & fetch_entry_ready_i;

    // full queue turns the entry away, fetch restarts at its address
    assign replay_o      = entry_valid_i & full;
    assign replay_addr_o = entry_i.addr;

    // head of the queue, stable until it is taken
    assign fetch_entry_valid_o = (count_q != '0);
    assign fetch_entry_o       = mem_q[rd_ptr_q];

    // ------------------------------------------------
    // pointers and fill level
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // drop all buffered entries
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leave the level unchanged
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push && !flush_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
// ------------------------------------------------
// fetch stage
// next-PC generation with redirect priority,
// cache request, registered response, static
// prediction and the push toward the queue
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "frontend_defines.svh"

module fetch_stage import frontend_pkg::*; (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic [`FE_VLEN-1:0]  boot_addr_i,
    input  wire logic                 flush_i,
    input  wire resolve_t             resolved_i,
    input  wire logic                 eret_i,
    input  wire logic [`FE_VLEN-1:0]  epc_i,
    input  wire logic                 ex_valid_i,
    input  wire logic [`FE_VLEN-1:0]  trap_vector_i,
    input  wire logic                 set_pc_commit_i,
    input  wire logic [`FE_VLEN-1:0]  pc_commit_i,
    input  wire logic                 set_debug_pc_i,
    output icache_req_t               icache_req_o,
    input  wire icache_rsp_t          icache_rsp_i,
    input  wire logic                 queue_ready_i,
    input  wire logic                 replay_i,
    input  wire logic [`FE_VLEN-1:0]  replay_addr_i,
    output fetch_entry_t              entry_o,
    output logic                      entry_valid_o
);

    // set for the first cycle out of reset so boot_addr_i gets loaded
    logic                 rst_load_q;
    logic [`FE_VLEN-1:0]  npc_d, npc_q;
    logic [`FE_VLEN-1:0]  fetch_addr;

    // registered cache response
    logic                 rsp_valid_q;
    logic                 rsp_ex_q;
    logic [31:0]          rsp_data_q;
    logic [`FE_VLEN-1:0]  rsp_addr_q;

    logic                 is_mispredict;
    logic                 kill_s1, kill_s2;
    logic                 bp_valid;
    cf_e                  scan_cf;
    cf_e                  entry_cf;
    logic [`FE_VLEN-1:0]  scan_target;

    // ------------------------------------------------
    // static prediction on the registered word
    // ------------------------------------------------
    instr_scan i_instr_scan (
        .instr_i  (rsp_data_q),
        .pc_i     (rsp_addr_q),
        .cf_o     (scan_cf),
        .target_o (scan_target)
    );

    // a faulting fetch carries no usable instruction
    assign entry_cf = rsp_ex_q ? cf_none : scan_cf;

    assign is_mispredict = resolved_i.valid;

    // push the registered word unless a flush or mispredict drops it,
    // a full queue answers the push with replay instead
    assign entry_valid_o = rsp_valid_q & ~(flush_i | is_mispredict);
    assign bp_valid      = entry_valid_o & (entry_cf != cf_none);

    // kill everything in flight on a redirect or replay
    assign kill_s1 = flush_i | is_mispredict | replay_i;
    // a taken prediction only drops the word arriving now
    assign kill_s2 = kill_s1 | bp_valid;

    assign entry_o.addr         = rsp_addr_q;
    assign entry_o.instr        = rsp_data_q;
    assign entry_o.ex           = rsp_ex_q;
    assign entry_o.cf           = entry_cf;
    assign entry_o.predict_addr = bp_valid ? scan_target : '0;

    // cache is always ready, so req high means accepted
    // quiet in reset and while the boot address is loaded
    assign icache_req_o.req  = queue_ready_i & ~kill_s1 & ~rst_load_q;
    assign icache_req_o.addr = fetch_addr;

    // ------------------------------------------------
    // next PC, later assignments win
    // ------------------------------------------------
    always_comb begin
        // hold by default, boot address right after reset
        if (rst_load_q) begin
            fetch_addr = boot_addr_i;
            npc_d      = boot_addr_i;
        end else begin
            fetch_addr = npc_q;
            npc_d      = npc_q;
        end
        // predicted target is fetched in this very cycle
        if (bp_valid) begin
            fetch_addr = scan_target;
            npc_d      = scan_target;
        end
        // sequential step on an accepted request
        if (icache_req_o.req) begin
            npc_d = {fetch_addr[`FE_VLEN-1:2], 2'b00} + `FE_VLEN'(`FE_INSTR_BYTES);
        end
        // refetch what the full queue turned away
        if (replay_i) begin
            npc_d = replay_addr_i;
        end
        if (is_mispredict) begin
            npc_d = resolved_i.target;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        if (ex_valid_i) begin
            npc_d = trap_vector_i;
        end
        // resume after the instruction in commit
        if (set_pc_commit_i) begin
            npc_d = pc_commit_i + `FE_VLEN'(`FE_INSTR_BYTES);
        end
        if (set_debug_pc_i) begin
            npc_d = `FE_DEBUG_ADDR;
        end
    end

    // ------------------------------------------------
    // registers
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rst_load_q  <= 1'b1;
            npc_q       <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            rst_load_q  <= 1'b0;
            npc_q       <= npc_d;
            // response arriving in a kill_s2 cycle is discarded
            rsp_valid_q <= icache_rsp_i.valid & ~kill_s2;
        end
    end

    always_ff @(posedge clk_i) begin
        if (icache_rsp_i.valid) begin
            rsp_ex_q   <= icache_rsp_i.ex;
            rsp_data_q <= icache_rsp_i.data;
            rsp_addr_q <= icache_rsp_i.addr;
        end
    end

endmodule

`default_nettype wire

// ==== instr_scan.sv ====
// ------------------------------------------------
// instruction scanner
// classifies one 32-bit instruction for control
// flow and makes a static taken/not-taken guess
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "frontend_defines.svh"

module instr_scan import frontend_pkg::*; (
    input  wire logic [31:0]          instr_i,
    input  wire logic [`FE_VLEN-1:0]  pc_i,
    output cf_e                       cf_o,
    output logic [`FE_VLEN-1:0]       target_o
);

    opcode_e              opcode;
    logic [`FE_VLEN-1:0]  b_imm;
    logic [`FE_VLEN-1:0]  j_imm;
    logic [`FE_VLEN-1:0]  imm;

    // major opcode, anything not listed is plain sequential code
    always_comb begin
        case (instr_i[6:0])
            op_branch: opcode = op_branch;
            op_jal:    opcode = op_jal;
            op_jalr:   opcode = op_jalr;
            default:   opcode = op_other;
        endcase
    end

    // B-type immediate, sign taken from bit 31
    assign b_imm = {{(`FE_VLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    // J-type immediate
    assign j_imm = {{(`FE_VLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // static prediction
    always_comb begin
        imm  = '0;
        cf_o = cf_none;
        case (opcode)
            op_branch: begin
                imm = b_imm;
                // backward branches are assumed to be loops
                if (b_imm[`FE_VLEN-1]) begin
                    cf_o = cf_branch;
                end
            end
            op_jal: begin
                imm  = j_imm;
                cf_o = cf_jump;
            end
            // jalr target is in a register, nothing to predict from
            default: begin
                imm  = '0;
                cf_o = cf_none;
            end
        endcase
    end

    // pc-relative target, equals pc when there is no control flow
    assign target_o = pc_i + imm;

endmodule

`default_nettype wire

// ==== frontend_pkg.sv ====
// ------------------------------------------------
// fetch frontend types
// opcodes, control-flow classes and the structs
// shared by the cache port, the redirect path
// and the instruction queue
// ------------------------------------------------
`default_nettype none

`include "frontend_defines.svh"

package frontend_pkg;

    // major opcodes the scanner tells apart
    typedef enum logic [6:0] {
        op_other  = 7'b0000000,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_e;

    // control flow recorded with each fetched instruction
    typedef enum logic [1:0] {
        cf_none   = 2'd0,
        cf_branch = 2'd1,
        cf_jump   = 2'd2
    } cf_e;

    // ------------------------------------------------
    // cache handshake
    // ------------------------------------------------
    typedef struct packed {
        logic                  req;
        logic [`FE_VLEN-1:0]   addr;
    } icache_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  ex;
        logic [31:0]           data;
        logic [`FE_VLEN-1:0]   addr;
    } icache_rsp_t;

    // branch unit says the prediction was wrong
    typedef struct packed {
        logic                  valid;
        logic [`FE_VLEN-1:0]   target;
    } resolve_t;

    // one queue slot toward decode
    typedef struct packed {
        logic [`FE_VLEN-1:0]   addr;
        logic [31:0]           instr;
        logic                  ex;
        cf_e                   cf;
        logic [`FE_VLEN-1:0]   predict_addr;
    } fetch_entry_t;

endpackage

`default_nettype wire

// ==== frontend_defines.svh ====
// ------------------------------------------------
// fetch frontend parameters
// address width, queue depth, debug entry point
// and the sequential fetch step
// ------------------------------------------------
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// virtual address width of the fetch path
`define FE_VLEN 32

// entries in the instruction queue toward decode
`define FE_QUEUE_DEPTH 4

// fixed debug entry, base of the debug module plus halt offset
`define FE_DEBUG_ADDR 32'h0000_0800

// one uncompressed instruction per fetch
`define FE_INSTR_BYTES 4

`endif
